//--- include/fetch_cfg.svh
/*
 * build-time constants for the fetch unit, shared by the RTL and the bench model.
 * include after the package import, wherever one of these values is needed.
 */
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// first PC after reset
`define FETCH_RESET_ADDR   32'h0000_1000

// first address past physical memory
`define FETCH_MEM_LIMIT    32'h0010_0000

// half-open hole in the memory map
`define FETCH_UNMAPPED_LO  32'h0008_0000
`define FETCH_UNMAPPED_HI  32'h0009_0000

// BTB index bits, taken from pc[IDX_W+1:2]
`define FETCH_BTB_IDX_W    4

// wait cycles before an unacknowledged read is dropped
`define FETCH_BUS_TIMEOUT  8

`endif

//--- hw/fetch_pkg.sv
/*
 * types shared by the fetch RTL and its bench: selectors, exceptions,
 * predictions, the fetch output record and the Wishbone signal bundles.
 */
`default_nettype none

package fetch_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] inst_t;

    typedef enum logic [1:0] {
        NEXT_PC_KEEP,
        NEXT_PC_BP_OR_4,
        NEXT_PC_JUMP,
        NEXT_PC_DEBUG
    } next_pc_sel_e;

    typedef enum logic [1:0] {
        EXC_NONE,
        EXC_ADDR_MISALIGNED,
        EXC_ACCESS_FAULT
    } exc_cause_e;

    typedef enum logic {
        PRED_NOT_TAKEN,
        PRED_TAKEN
    } pred_e;

    typedef enum logic [1:0] {
        IDLE,
        BUS,
        HOLD
    } fetch_state_e;

    typedef struct packed {
        logic       valid;
        exc_cause_e cause;
        addr_t      origin;
    } exc_t;

    typedef struct packed {
        logic  is_branch;
        pred_e decision;
        addr_t pred_addr;
    } bpred_t;

    typedef struct packed {
        logic   valid;
        addr_t  pc;
        inst_t  inst;
        exc_t   ex;
        bpred_t bpred;
    } fetch_out_t;

    // resolved branch from execute, trains the BTB
    typedef struct packed {
        logic  is_branch;
        logic  taken;
        addr_t pc;
        addr_t target;
    } exe_bp_update_t;

    typedef struct packed {
        logic  cyc;
        logic  stb;
        logic  we;
        addr_t adr;
    } wb_m2s_t;

    typedef struct packed {
        logic  ack;
        inst_t dat;
    } wb_s2m_t;

endpackage

`default_nettype wire

//--- hw/pc_gen.sv
/*
 * fetch PC register with next-PC selection, loaded only on a consume pulse.
 * also flags misaligned and unmapped PCs before the bus is touched.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module pc_gen import fetch_pkg::*; (
    input  logic         clk_i,
    input  logic         rstn_i,
    input  next_pc_sel_e next_pc_sel_i,
    input  addr_t        pc_jump_i,
    input  logic         consume_i,
    input  bpred_t       bpred_i,
    output addr_t        pc_o,
    output exc_t         exc_o
);

    addr_t pc_q;
    addr_t next_pc;
    logic  misaligned;
    logic  access_fault;

    // next PC source
    always_comb begin
        next_pc = pc_q;
        unique case (next_pc_sel_i)
            NEXT_PC_KEEP: begin
                next_pc = pc_q;
            end
            NEXT_PC_BP_OR_4: begin
                if (bpred_i.is_branch && bpred_i.decision == PRED_TAKEN) begin
                    next_pc = bpred_i.pred_addr;
                end else begin
                    next_pc = pc_q + 32'd4;
                end
            end
            NEXT_PC_JUMP,
            NEXT_PC_DEBUG: begin
                next_pc = pc_jump_i;
            end
        endcase
    end

    // PC moves only when the consumer takes the current instruction
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q <= `FETCH_RESET_ADDR;
        end else if (consume_i) begin
            pc_q <= next_pc;
        end
    end

    assign misaligned   = |pc_q[1:0];
    assign access_fault = (pc_q >= `FETCH_UNMAPPED_LO && pc_q < `FETCH_UNMAPPED_HI)
                        || pc_q >= `FETCH_MEM_LIMIT;

    // misaligned wins over access fault
    always_comb begin
        exc_o.origin = pc_q;
        if (misaligned) begin
            exc_o.valid = 1'b1;
            exc_o.cause = EXC_ADDR_MISALIGNED;
        end else if (access_fault) begin
            exc_o.valid = 1'b1;
            exc_o.cause = EXC_ACCESS_FAULT;
        end else begin
            exc_o.valid = 1'b0;
            exc_o.cause = EXC_NONE;
        end
    end

    assign pc_o = pc_q;

endmodule

`default_nettype wire

//--- hw/branch_predictor.sv
/*
 * direct-mapped BTB with 2-bit counters. lookup is combinational on the
 * fetch PC; resolved branches from execute write the entry at the next edge.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module branch_predictor import fetch_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  addr_t          pc_i,
    input  exe_bp_update_t exe_bp_i,
    output bpred_t         bpred_o
);

    localparam int IDX_W   = `FETCH_BTB_IDX_W;
    localparam int ENTRIES = 1 << IDX_W;
    localparam int TAG_W   = 32 - 2 - IDX_W;

    logic [ENTRIES-1:0] valid_q;
    logic [TAG_W-1:0]   tag_q    [ENTRIES];
    addr_t              target_q [ENTRIES];
    logic [1:0]         cnt_q    [ENTRIES];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic             rd_hit;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;
    logic             wr_hit;

    // lookup side
    assign rd_idx = pc_i[IDX_W+1:2];
    assign rd_tag = pc_i[31:IDX_W+2];
    assign rd_hit = valid_q[rd_idx] && tag_q[rd_idx] == rd_tag;

    assign bpred_o.is_branch = rd_hit;
    assign bpred_o.decision  = (rd_hit && cnt_q[rd_idx][1]) ? PRED_TAKEN : PRED_NOT_TAKEN;
    // fall-through address when nothing is known about this pc
    assign bpred_o.pred_addr = rd_hit ? target_q[rd_idx] : pc_i + 32'd4;

    // update side
    assign wr_idx = exe_bp_i.pc[IDX_W+1:2];
    assign wr_tag = exe_bp_i.pc[31:IDX_W+2];
    assign wr_hit = valid_q[wr_idx] && tag_q[wr_idx] == wr_tag;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (exe_bp_i.is_branch && exe_bp_i.taken) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exe_bp_i.is_branch) begin
            if (wr_hit) begin
                target_q[wr_idx] <= exe_bp_i.target;
                // saturating step toward the outcome
                if (exe_bp_i.taken && cnt_q[wr_idx] != 2'd3) begin
                    cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
                end else if (!exe_bp_i.taken && cnt_q[wr_idx] != 2'd0) begin
                    cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
                end
            end else if (exe_bp_i.taken) begin
                // new entry starts weakly taken
                tag_q[wr_idx]    <= wr_tag;
                target_q[wr_idx] <= exe_bp_i.target;
                cnt_q[wr_idx]    <= 2'd2;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/fetch_ctrl.sv
/*
 * fetch FSM: one Wishbone classic read per PC, then holds the result on
 * fetch_o until the consumer takes it. pre-checked exceptions skip the bus.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl import fetch_pkg::*; (
    input  logic       clk_i,
    input  logic       rstn_i,
    input  addr_t      pc_i,
    input  exc_t       exc_i,
    input  bpred_t     bpred_i,
    input  logic       stall_i,
    input  wb_s2m_t    wb_i,
    input  logic       expired_i,
    output wb_m2s_t    wb_o,
    output logic       run_o,
    output logic       consume_o,
    output fetch_out_t fetch_o
);

    fetch_state_e state_q;
    fetch_state_e state_d;

    inst_t  inst_q;
    exc_t   ex_q;
    bpred_t bpred_q;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            IDLE: begin
                state_d = exc_i.valid ? HOLD : BUS;
            end
            BUS: begin
                if (wb_i.ack || expired_i) begin
                    state_d = HOLD;
                end
            end
            HOLD: begin
                if (!stall_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // result capture on the way into HOLD, frozen while held
    always_ff @(posedge clk_i) begin
        if (state_d == HOLD && state_q != HOLD) begin
            bpred_q <= bpred_i;
            if (state_q == IDLE) begin
                inst_q <= '0;
                ex_q   <= exc_i;
            end else if (wb_i.ack) begin
                // ack beats a simultaneous timeout
                inst_q    <= wb_i.dat;
                ex_q      <= exc_i;
            end else begin
                inst_q    <= '0;
                ex_q.valid  <= 1'b1;
                ex_q.cause  <= EXC_ACCESS_FAULT;
                ex_q.origin <= pc_i;
            end
        end
    end

    // bus side, cyc and stb follow the state register
    assign wb_o.cyc = state_q == BUS;
    assign wb_o.stb = state_q == BUS;
    assign wb_o.we  = 1'b0;
    assign wb_o.adr = pc_i;
    assign run_o    = state_q == BUS;

    assign consume_o = state_q == HOLD && !stall_i;

    // pc only changes on consume, so it is stable for the whole hold
    assign fetch_o.valid = state_q == HOLD;
    assign fetch_o.pc    = pc_i;
    assign fetch_o.inst  = inst_q;
    assign fetch_o.ex    = ex_q;
    assign fetch_o.bpred = bpred_q;

endmodule

`default_nettype wire

//--- hw/bus_timer.sv
/*
 * wait-cycle counter for one Wishbone read. expired_o is raised in the
 * cycle where stb has been high FETCH_BUS_TIMEOUT cycles without an ack.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module bus_timer (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic run_i,
    input  logic ack_i,
    output logic expired_o
);

    localparam int TIMEOUT = `FETCH_BUS_TIMEOUT;
    localparam int CNT_W   = $clog2(TIMEOUT + 1);

    logic [CNT_W-1:0] cnt_q;
    logic             at_limit;

    assign at_limit = cnt_q == CNT_W'(TIMEOUT - 1);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            cnt_q <= '0;
        end else if (!run_i || ack_i) begin
            cnt_q <= '0;
        end else if (!at_limit) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign expired_o = run_i && !ack_i && at_limit;

endmodule

`default_nettype wire

//--- hw/fetch_top.sv
/*
 * fetch front end top level. connects PC generation, the BTB, the fetch FSM
 * and the bus timer; the Wishbone slave and the consumer sit outside.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_top import fetch_pkg::*; (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  next_pc_sel_e   next_pc_sel_i,
    input  addr_t          pc_jump_i,
    input  logic           stall_i,
    input  exe_bp_update_t exe_bp_i,
    input  wb_s2m_t        wb_i,
    output fetch_out_t     fetch_o,
    output wb_m2s_t        wb_o
);

    addr_t  pc;
    exc_t   exc;
    bpred_t bpred;
    logic   consume;
    logic   run;
    logic   expired;

    pc_gen pc_gen0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .next_pc_sel_i (next_pc_sel_i),
        .pc_jump_i     (pc_jump_i),
        .consume_i     (consume),
        .bpred_i       (bpred),
        .pc_o          (pc),
        .exc_o         (exc)
    );

    branch_predictor bp0 (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .pc_i     (pc),
        .exe_bp_i (exe_bp_i),
        .bpred_o  (bpred)
    );

    fetch_ctrl ctrl0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .pc_i      (pc),
        .exc_i     (exc),
        .bpred_i   (bpred),
        .stall_i   (stall_i),
        .wb_i      (wb_i),
        .expired_i (expired),
        .wb_o      (wb_o),
        .run_o     (run),
        .consume_o (consume),
        .fetch_o   (fetch_o)
    );

    // watches the read that ctrl0 has in flight
    bus_timer timer0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .run_i     (run),
        .ack_i     (wb_i.ack),
        .expired_o (expired)
    );

endmodule

`default_nettype wire

//--- bench/fetch_checker.sv
/*
 * Wishbone and hold-rule assertions, bound into fetch_ctrl by the bench.
 * err_cnt holds the number of failed assertions.
 */
`timescale 1ns/1ps
`default_nettype none

module fetch_checker import fetch_pkg::*; (
    input logic       clk_i,
    input logic       rstn_i,
    input logic       stall_i,
    input logic       expired_i,
    input wb_s2m_t    wb_i,
    input wb_m2s_t    wb_o,
    input fetch_out_t fetch_o
);

    int err_cnt = 0;

    // stalled output must not move
    hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_o.valid && stall_i |=> $stable(fetch_o))
        else begin
            $error("fetch_o changed while stalled");
            err_cnt++;
        end

    we_low_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !wb_o.we)
        else begin
            $error("we is set on an instruction read");
            err_cnt++;
        end

    // strobe held until ack or expiry
    cyc_hold_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.cyc && !wb_i.ack && !expired_i |=> wb_o.cyc && wb_o.stb)
        else begin
            $error("cycle dropped before ack or expiry");
            err_cnt++;
        end

    cyc_end_a: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_o.cyc && (wb_i.ack || expired_i) |=> !wb_o.cyc)
        else begin
            $error("cyc still high after ack or expiry");
            err_cnt++;
        end

endmodule

`default_nettype wire

//--- bench/fetch_tb.sv
/*
 * fetch unit bench: LFSR-driven redirects, stalls and BTB training against a
 * reference model, with a Wishbone memory that returns address ^ MEM_KEY.
 */
`timescale 1ns/1ps
`default_nettype none

`include "fetch_cfg.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int    CLK_PERIOD   = 20;
    localparam int    RESET_CYCLES = 16;
    localparam int    N_OPS        = 400;
    localparam int    IDX_W        = `FETCH_BTB_IDX_W;
    localparam int    ENTRIES      = 1 << IDX_W;
    localparam addr_t MEM_KEY      = 32'h5a5a_c3c3;
    // idle, full timeout, capture, three stall cycles and consume, plus slack
    localparam int    OP_CYCLES    = `FETCH_BUS_TIMEOUT + 10;
    localparam int    WATCHDOG_NS  = (RESET_CYCLES + N_OPS * OP_CYCLES) * CLK_PERIOD;

    logic           clk_i;
    logic           rstn_i;
    next_pc_sel_e   next_pc_sel_i;
    addr_t          pc_jump_i;
    logic           stall_i;
    exe_bp_update_t exe_bp_i;
    wb_s2m_t        wb_i;
    fetch_out_t     fetch_o;
    wb_m2s_t        wb_o;

    logic [31:0] lfsr_q;
    logic        no_ack;
    int          wait_cfg;
    int          bus_count;

    // model BTB keeps the full branch pc for the tag compare
    logic        m_valid  [ENTRIES];
    addr_t       m_pc     [ENTRIES];
    addr_t       m_target [ENTRIES];
    logic [1:0]  m_cnt    [ENTRIES];

    fetch_top dut0 (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .next_pc_sel_i (next_pc_sel_i),
        .pc_jump_i     (pc_jump_i),
        .stall_i       (stall_i),
        .exe_bp_i      (exe_bp_i),
        .wb_i          (wb_i),
        .fetch_o       (fetch_o),
        .wb_o          (wb_o)
    );

    bind fetch_ctrl fetch_checker chk0 (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .stall_i   (stall_i),
        .expired_i (expired_i),
        .wb_i      (wb_i),
        .wb_o      (wb_o),
        .fetch_o   (fetch_o)
    );

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'hd000_0001) : (lfsr_q >> 1);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // mostly aligned near reset, sometimes misaligned, unmapped or past the limit
    function automatic addr_t random_addr();
        logic [2:0] kind;
        kind = 3'(rand_bits(3));
        case (kind)
            3'd5: return `FETCH_RESET_ADDR + (rand_bits(8) << 2) + 32'd2;
            3'd6: return `FETCH_UNMAPPED_LO + (rand_bits(12) << 2);
            3'd7: return `FETCH_MEM_LIMIT + rand_bits(14);
            default: return `FETCH_RESET_ADDR + (rand_bits(8) << 2);
        endcase
    endfunction

    function automatic exc_t expected_exc(input addr_t pc);
        exc_t e;
        e.origin = pc;
        e.valid  = 1'b1;
        if (pc[1:0] != 2'b00) begin
            e.cause = EXC_ADDR_MISALIGNED;
        end else if ((pc >= `FETCH_UNMAPPED_LO && pc < `FETCH_UNMAPPED_HI)
                     || pc >= `FETCH_MEM_LIMIT) begin
            e.cause = EXC_ACCESS_FAULT;
        end else begin
            e.valid = 1'b0;
            e.cause = EXC_NONE;
        end
        return e;
    endfunction

    function automatic bpred_t lookup_btb(input addr_t pc);
        bpred_t p;
        int     idx;
        idx         = int'(pc[IDX_W+1:2]);
        p.is_branch = m_valid[idx] && m_pc[idx][31:IDX_W+2] == pc[31:IDX_W+2];
        p.decision  = (p.is_branch && m_cnt[idx] >= 2'd2) ? PRED_TAKEN : PRED_NOT_TAKEN;
        p.pred_addr = p.is_branch ? m_target[idx] : pc + 32'd4;
        return p;
    endfunction

    function automatic void train_btb(input exe_bp_update_t u);
        int   idx;
        logic hit;
        idx = int'(u.pc[IDX_W+1:2]);
        hit = m_valid[idx] && m_pc[idx][31:IDX_W+2] == u.pc[31:IDX_W+2];
        if (u.is_branch && hit) begin
            m_target[idx] = u.target;
            if (u.taken && m_cnt[idx] != 2'd3) begin
                m_cnt[idx] = m_cnt[idx] + 2'd1;
            end else if (!u.taken && m_cnt[idx] != 2'd0) begin
                m_cnt[idx] = m_cnt[idx] - 2'd1;
            end
        end else if (u.is_branch && u.taken) begin
            m_valid[idx]  = 1'b1;
            m_pc[idx]     = u.pc;
            m_target[idx] = u.target;
            m_cnt[idx]    = 2'd2;
        end
    endfunction

    task automatic check_eq(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %h, actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // Wishbone slave with wait_cfg wait states that never acks while no_ack is set
    initial begin
        int waited;
        wb_i      = '0;
        waited    = 0;
        bus_count = 0;
        forever begin
            @(negedge clk_i);
            wb_i.ack = 1'b0;
            if (wb_o.cyc && wb_o.stb) begin
                bus_count++;
                if (!no_ack && waited == wait_cfg) begin
                    wb_i.ack = 1'b1;
                    wb_i.dat = wb_o.adr ^ MEM_KEY;
                end
                waited++;
            end else begin
                waited = 0;
            end
        end
    end

    always @(negedge clk_i) begin
        if (dut0.ctrl0.chk0.err_cnt != 0) begin
            $display("protocol assertion failed, see error above");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: fetch output did not arrive in time");
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        addr_t      model_pc;
        addr_t      next_pc;
        addr_t      jump;
        exc_t       pre_ex;
        exc_t       exp_ex;
        bpred_t     pred;
        logic [2:0] sel;
        logic       timed_out;
        int         n_stall;
        int         bus_mark;
        string      sel_name;

        lfsr_q        = 32'h597d;
        rstn_i        = 1'b0;
        next_pc_sel_i = NEXT_PC_BP_OR_4;
        pc_jump_i     = '0;
        stall_i       = 1'b0;
        exe_bp_i      = '0;
        no_ack        = 1'b0;
        wait_cfg      = 0;
        bus_mark      = 0;
        model_pc      = `FETCH_RESET_ADDR;
        sel_name      = "reset";
        for (int i = 0; i < ENTRIES; i++) begin
            m_valid[i] = 1'b0;
        end

        repeat (RESET_CYCLES) @(negedge clk_i);
        check_eq("valid in reset", 0, fetch_o.valid);
        check_eq("cyc in reset", 0, wb_o.cyc);
        check_eq("pc in reset", `FETCH_RESET_ADDR, fetch_o.pc);
        rstn_i = 1'b1;

        for (int op = 0; op < N_OPS; op++) begin
            do @(negedge clk_i); while (!fetch_o.valid);

            pre_ex    = expected_exc(model_pc);
            exp_ex    = pre_ex;
            timed_out = !exp_ex.valid && no_ack;
            if (timed_out) begin
                exp_ex.valid = 1'b1;
                exp_ex.cause = EXC_ACCESS_FAULT;
            end
            check_eq({"pc after ", sel_name}, model_pc, fetch_o.pc);
            check_eq("inst", exp_ex.valid ? 32'd0 : model_pc ^ MEM_KEY, fetch_o.inst);
            check_eq("exception", exp_ex, fetch_o.ex);
            check_eq("prediction", lookup_btb(model_pc), fetch_o.bpred);
            check_eq("bus cycle issued", !pre_ex.valid, bus_count != bus_mark);
            check_eq("cyc after fetch", 0, wb_o.cyc);

            // stall while execute trains the BTB
            n_stall = rand_bits(2);
            for (int s = 0; s < n_stall; s++) begin
                stall_i = 1'b1;
                exe_bp_i.is_branch = rand_bits(1) != 0;
                exe_bp_i.taken     = rand_bits(2) != 0;
                exe_bp_i.pc        = model_pc + (rand_bits(2) << 2);
                exe_bp_i.target    = `FETCH_RESET_ADDR + (rand_bits(8) << 2);
                train_btb(exe_bp_i);
                @(negedge clk_i);
            end

            sel  = 3'(rand_bits(3));
            jump = random_addr();
            pred = lookup_btb(model_pc);
            case (sel)
                3'd0: begin
                    next_pc_sel_i = NEXT_PC_KEEP;
                    sel_name      = "KEEP";
                    next_pc       = model_pc;
                end
                3'd1: begin
                    next_pc_sel_i = NEXT_PC_JUMP;
                    sel_name      = "JUMP";
                    next_pc       = jump;
                end
                3'd2: begin
                    next_pc_sel_i = NEXT_PC_DEBUG;
                    sel_name      = "DEBUG";
                    next_pc       = jump;
                end
                default: begin
                    next_pc_sel_i = NEXT_PC_BP_OR_4;
                    sel_name      = "BP_OR_4";
                    next_pc = (pred.is_branch && pred.decision == PRED_TAKEN)
                            ? pred.pred_addr : model_pc + 32'd4;
                end
            endcase
            pc_jump_i          = jump;
            exe_bp_i.is_branch = 1'b0;
            stall_i            = 1'b0;
            wait_cfg           = rand_bits(2);
            no_ack             = rand_bits(4) == 0;
            bus_mark           = bus_count;
            @(posedge clk_i);
            model_pc = next_pc;
        end

        repeat (2) @(negedge clk_i);
        if (dut0.ctrl0.chk0.err_cnt != 0) begin
            $display("protocol assertions failed during the run");
            $display("TESTS FAILED");
            $fatal(1, "assertion failure");
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
hw/fetch_pkg.sv
hw/pc_gen.sv
hw/branch_predictor.sv
hw/fetch_ctrl.sv
hw/bus_timer.sv
hw/fetch_top.sv
bench/fetch_checker.sv
bench/fetch_tb.sv
